/* rtl/hdr_proc_params.svh */
`ifndef HDR_PROC_PARAMS_SVH
`define HDR_PROC_PARAMS_SVH

// ==============================
// datapath sizes.
// ==============================
`define HP_DATA_BYTES   4
`define HP_PREFIX_WORDS 4
`define HP_FIFO_DEPTH   16
`define HP_WB_ADR_W     4
`define HP_TRUNC_W      8
`define HP_DROP_CNT_W   16

// ==============================
// wishbone register map, word addresses.
// ==============================
`define HP_REG_CTRL       4'h0
`define HP_REG_DROP_PAT   4'h1
`define HP_REG_PREFIX_LEN 4'h2
`define HP_REG_TRUNC_LEN  4'h3
// prefix words occupy four consecutive addresses from here.
`define HP_REG_PREFIX0    4'h4
`define HP_REG_DROP_CNT   4'h8

`endif

/* rtl/hdr_proc_pkg.sv */
`default_nettype none

`include "hdr_proc_params.svh"

package hdr_proc_pkg;

   // ==============================
   // plain vector types.
   // ==============================
   typedef logic [8*`HP_DATA_BYTES-1:0] word_t;
   typedef logic [`HP_DATA_BYTES-1:0] keep_t;
   typedef logic [`HP_TRUNC_W-1:0] trunc_len_t;
   typedef logic [`HP_DROP_CNT_W-1:0] drop_cnt_t;
   typedef logic [`HP_WB_ADR_W-1:0] wb_adr_t;
   // wide enough for 0 up to the maximum prefix count.
   typedef logic [$clog2(`HP_PREFIX_WORDS+1)-1:0] prefix_len_t;

   // ==============================
   // bundles.
   // ==============================
   // one stream beat, byte 0 sits in the top lane.
   typedef struct packed {
      word_t tdata;
      keep_t tkeep;
      logic  tlast;
   } axis_word_t;

   // wishbone classic master side.
   typedef struct packed {
      logic    cyc;
      logic    stb;
      logic    we;
      wb_adr_t adr;
      word_t   dat;
   } wb_req_t;

   // wishbone classic slave side.
   typedef struct packed {
      logic  ack;
      word_t dat;
   } wb_rsp_t;

   // configuration seen by every datapath stage.
   typedef struct packed {
      logic                             drop_en;
      logic                             drop_mode;
      word_t                            drop_pat;
      prefix_len_t                      prefix_len;
      trunc_len_t                       trunc_len;
      word_t [`HP_PREFIX_WORDS-1:0]     prefix;
   } hdr_cfg_t;

endpackage

`default_nettype wire

/* rtl/hdr_cfg_regs.sv */
`default_nettype none

`include "hdr_proc_params.svh"

module hdr_cfg_regs import hdr_proc_pkg::*; (
   input  logic     axi4s_in,
   input  logic     rst_n,
   input  wb_req_t  wb_req,
   input  logic     drop_hit,
   output wb_rsp_t  wb_rsp,
   output hdr_cfg_t cfg
);

   localparam int PIDX_W = $clog2(`HP_PREFIX_WORDS);

   logic      ack_q;
   word_t     dat_q;
   word_t     rd_dat;
   logic      acc;
   logic      wr_en;
   logic      is_prefix;
   wb_adr_t   pidx;
   drop_cnt_t drop_cnt;

   // ==============================
   // access decode.
   // ==============================
   // one access per strobe, the ack cycle itself is ignored.
   assign acc   = wb_req.cyc && wb_req.stb && !ack_q;
   assign wr_en = acc && wb_req.we;

   // prefix window and offset within it.
   assign is_prefix = (wb_req.adr >= `HP_REG_PREFIX0) &&
                      (wb_req.adr < `HP_REG_PREFIX0 + `HP_PREFIX_WORDS);
   assign pidx      = wb_req.adr - `HP_REG_PREFIX0;

   // read mux.
   // unmapped addresses read as zero.
   always_comb begin
      rd_dat = '0;
      case (wb_req.adr)
         `HP_REG_CTRL: begin
            rd_dat[0] = cfg.drop_en;
            rd_dat[1] = cfg.drop_mode;
         end
         `HP_REG_DROP_PAT:   rd_dat = cfg.drop_pat;
         `HP_REG_PREFIX_LEN: rd_dat = word_t'(cfg.prefix_len);
         `HP_REG_TRUNC_LEN:  rd_dat = word_t'(cfg.trunc_len);
         `HP_REG_DROP_CNT:   rd_dat = word_t'(drop_cnt);
         default: begin
            if (is_prefix) rd_dat = cfg.prefix[pidx[PIDX_W-1:0]];
         end
      endcase
   end

   // ==============================
   // configuration registers.
   // ==============================
   always_ff @(posedge axi4s_in or negedge rst_n) begin
      if (!rst_n) begin
         cfg <= '0;
      end else if (wr_en) begin
         case (wb_req.adr)
            `HP_REG_CTRL: begin
               cfg.drop_en   <= wb_req.dat[0];
               cfg.drop_mode <= wb_req.dat[1];
            end
            `HP_REG_DROP_PAT: cfg.drop_pat <= wb_req.dat;
            // prefix count is clamped to the number of prefix words.
            `HP_REG_PREFIX_LEN: begin
               if (wb_req.dat > `HP_PREFIX_WORDS) begin
                  cfg.prefix_len <= prefix_len_t'(`HP_PREFIX_WORDS);
               end else begin
                  cfg.prefix_len <= wb_req.dat[$bits(prefix_len_t)-1:0];
               end
            end
            `HP_REG_TRUNC_LEN: cfg.trunc_len <= wb_req.dat[`HP_TRUNC_W-1:0];
            default: begin
               if (is_prefix) cfg.prefix[pidx[PIDX_W-1:0]] <= wb_req.dat;
            end
         endcase
      end
   end

   // saturating drop counter.
   // any write to its address clears it, clear wins over a hit.
   always_ff @(posedge axi4s_in or negedge rst_n) begin
      if (!rst_n) begin
         drop_cnt <= '0;
      end else if (wr_en && (wb_req.adr == `HP_REG_DROP_CNT)) begin
         drop_cnt <= '0;
      end else if (drop_hit && (drop_cnt != '1)) begin
         drop_cnt <= drop_cnt + 1'b1;
      end
   end

   // ==============================
   // response.
   // ==============================
   // ack one cycle after the strobe, for one cycle.
   always_ff @(posedge axi4s_in or negedge rst_n) begin
      if (!rst_n) ack_q <= 1'b0;
      else        ack_q <= acc;
   end

   // read data valid while ack is high.
   always_ff @(posedge axi4s_in) begin
      if (acc) dat_q <= rd_dat;
   end

   assign wb_rsp = '{ack: ack_q, dat: dat_q};

endmodule

`default_nettype wire

/* rtl/hdr_drop_filter.sv */
`default_nettype none

module hdr_drop_filter import hdr_proc_pkg::*; (
   input  logic       axi4s_in,
   input  logic       rst_n,
   input  hdr_cfg_t   cfg,
   input  axis_word_t in_word,
   input  logic       in_valid,
   output logic       in_ready,
   output axis_word_t out_word,
   output logic       out_valid,
   input  logic       out_ready,
   output logic       drop_hit
);

   typedef enum logic [1:0] {first, pass, discard} state_t;

   state_t state;
   state_t state_nxt;
   logic   match;
   logic   in_xfer;

   // pattern check only on the first word of a packet.
   assign match = cfg.drop_en && (state == first) && (in_word.tdata == cfg.drop_pat);

   // ==============================
   // stream path.
   // ==============================
   always_comb begin
      out_word  = in_word;
      out_valid = in_valid;
      in_ready  = out_ready;
      if (state == discard) begin
         // tail of a dropped packet, swallow it.
         out_valid = 1'b0;
         in_ready  = 1'b1;
      end else if (match) begin
         if (cfg.drop_mode) begin
            // mode 1, nothing of the packet goes out.
            out_valid = 1'b0;
            in_ready  = 1'b1;
         end else begin
            // mode 0, empty marker word closes the packet.
            out_word.tkeep = '0;
            out_word.tlast = 1'b1;
         end
      end
   end

   assign in_xfer  = in_valid && in_ready;
   // one pulse per dropped packet.
   assign drop_hit = in_xfer && match;

   // ==============================
   // packet position.
   // ==============================
   always_comb begin
      state_nxt = state;
      if (in_xfer) begin
         if (in_word.tlast)       state_nxt = first;
         else if (match)          state_nxt = discard;
         else if (state == first) state_nxt = pass;
      end
   end

   always_ff @(posedge axi4s_in or negedge rst_n) begin
      if (!rst_n) state <= first;
      else        state <= state_nxt;
   end

endmodule

`default_nettype wire

/* rtl/hdr_prefix_insert.sv */
`default_nettype none

`include "hdr_proc_params.svh"

module hdr_prefix_insert import hdr_proc_pkg::*; (
   input  logic       axi4s_in,
   input  logic       rst_n,
   input  hdr_cfg_t   cfg,
   input  axis_word_t in_word,
   input  logic       in_valid,
   output logic       in_ready,
   output axis_word_t out_word,
   output logic       out_valid,
   input  logic       out_ready
);

   localparam int PIDX_W = $clog2(`HP_PREFIX_WORDS);

   logic        pipe_valid;
   axis_word_t  pipe_word;
   prefix_len_t idx;
   logic        add_prefix;
   logic        out_xfer;
   logic        pipe_pop;
   axis_word_t  prefix_word;

   // ==============================
   // input pipe stage.
   // ==============================
   // pipe drains only on real packet words, not on prefix words.
   assign pipe_pop = out_xfer && !add_prefix;
   assign in_ready = !pipe_valid || pipe_pop;

   always_ff @(posedge axi4s_in or negedge rst_n) begin
      if (!rst_n) begin
         pipe_valid <= 1'b0;
      end else if (in_ready) begin
         pipe_valid <= in_valid;
      end
   end

   always_ff @(posedge axi4s_in) begin
      if (in_valid && in_ready) pipe_word <= in_word;
   end

   // ==============================
   // prefix injection.
   // ==============================
   // idx counts prefix words already sent for the current packet.
   assign add_prefix = idx < cfg.prefix_len;

   // prefix words go out only while the first word waits in the pipe.
   assign out_valid = pipe_valid;
   assign out_xfer  = out_valid && out_ready;

   always_comb begin
      prefix_word.tdata = cfg.prefix[idx[PIDX_W-1:0]];
      prefix_word.tkeep = '1;
      prefix_word.tlast = 1'b0;
   end

   assign out_word = add_prefix ? prefix_word : pipe_word;

   // back to zero once the packet's last word has left.
   always_ff @(posedge axi4s_in or negedge rst_n) begin
      if (!rst_n) begin
         idx <= '0;
      end else if (out_xfer) begin
         if (add_prefix) begin
            idx <= idx + 1'b1;
         end else if (pipe_word.tlast) begin
            idx <= '0;
         end
      end
   end

endmodule

`default_nettype wire

/* rtl/hdr_truncate.sv */
`default_nettype none

`include "hdr_proc_params.svh"

module hdr_truncate import hdr_proc_pkg::*; (
   input  logic       axi4s_in,
   input  logic       rst_n,
   input  hdr_cfg_t   cfg,
   input  axis_word_t in_word,
   input  logic       in_valid,
   output logic       in_ready,
   output axis_word_t out_word,
   output logic       out_valid,
   input  logic       out_ready
);

   typedef enum logic {count, discard} state_t;

   state_t             state;
   trunc_len_t         cnt;
   trunc_len_t         remain;
   logic [`HP_TRUNC_W:0] sum;
   logic               marker;
   logic               limit_hit;
   logic               in_xfer;
   keep_t              mask;

   // number of valid bytes, tkeep is contiguous from byte 0.
   function automatic trunc_len_t keep_bytes(keep_t k);
      trunc_len_t n;
      n = '0;
      for (int i = 0; i < `HP_DATA_BYTES; i++) begin
         if (k[i]) n = n + 1'b1;
      end
      return n;
   endfunction

   // ==============================
   // limit check.
   // ==============================
   assign marker    = (in_word.tkeep == '0) && in_word.tlast;
   assign sum       = {1'b0, cnt} + {1'b0, keep_bytes(in_word.tkeep)};
   assign remain    = cfg.trunc_len - cnt;
   // zero length means truncation off.
   assign limit_hit = (cfg.trunc_len != '0) && !marker && (sum >= cfg.trunc_len);

   // keep only the first remain bytes, byte 0 in the top lane.
   always_comb begin
      for (int i = 0; i < `HP_DATA_BYTES; i++) begin
         mask[`HP_DATA_BYTES-1-i] = (i < remain);
      end
   end

   // ==============================
   // stream path.
   // ==============================
   always_comb begin
      out_word  = in_word;
      out_valid = in_valid;
      in_ready  = out_ready;
      if (state == discard) begin
         out_valid = 1'b0;
         in_ready  = 1'b1;
      end else if (limit_hit) begin
         out_word.tkeep = in_word.tkeep & mask;
         out_word.tlast = 1'b1;
      end
   end

   assign in_xfer = in_valid && in_ready;

   // byte count and tail discard.
   always_ff @(posedge axi4s_in or negedge rst_n) begin
      if (!rst_n) begin
         state <= count;
         cnt   <= '0;
      end else if (in_xfer) begin
         if (in_word.tlast) begin
            state <= count;
            cnt   <= '0;
         end else if (state == count) begin
            if (limit_hit) begin
               state <= discard;
               cnt   <= '0;
            end else begin
               cnt <= sum[`HP_TRUNC_W-1:0];
            end
         end
      end
   end

endmodule

`default_nettype wire

/* rtl/hdr_pkt_fifo.sv */
`default_nettype none

`include "hdr_proc_params.svh"

module hdr_pkt_fifo import hdr_proc_pkg::*; #(
   parameter int DEPTH = `HP_FIFO_DEPTH
) (
   input  logic       axi4s_in,
   input  logic       rst_n,
   input  axis_word_t in_word,
   input  logic       in_valid,
   output logic       in_ready,
   output axis_word_t out_word,
   output logic       out_valid,
   input  logic       out_ready
);

   localparam int AW = $clog2(DEPTH);

   axis_word_t    mem [DEPTH];
   logic [AW:0]   wr_ptr;
   logic [AW:0]   rd_ptr;
   logic          mem_empty;
   logic          mem_full;
   logic          push;
   logic          load;
   logic          bypass;
   logic          mem_wr;
   logic          mem_rd;

   // ==============================
   // pointer state.
   // ==============================
   // extra pointer bit tells full from empty.
   assign mem_empty = (wr_ptr == rd_ptr);
   assign mem_full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

   assign in_ready = !mem_full;
   assign push     = in_valid && in_ready;

   // output register free, or emptied this cycle.
   assign load   = !out_valid || out_ready;
   // empty fifo sends the word straight to the output register.
   assign bypass = push && load && mem_empty;
   assign mem_wr = push && !bypass;
   assign mem_rd = load && !mem_empty;

   always_ff @(posedge axi4s_in or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (mem_wr) wr_ptr <= wr_ptr + 1'b1;
         if (mem_rd) rd_ptr <= rd_ptr + 1'b1;
      end
   end

   always_ff @(posedge axi4s_in) begin
      if (mem_wr) mem[wr_ptr[AW-1:0]] <= in_word;
   end

   // ==============================
   // registered output.
   // ==============================
   always_ff @(posedge axi4s_in or negedge rst_n) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
      end else if (load) begin
         out_valid <= mem_rd || bypass;
      end
   end

   // stored words go first, this keeps order.
   always_ff @(posedge axi4s_in) begin
      if (mem_rd)      out_word <= mem[rd_ptr[AW-1:0]];
      else if (bypass) out_word <= in_word;
   end

endmodule

`default_nettype wire

/* rtl/hdr_proc.sv */
`default_nettype none

module hdr_proc import hdr_proc_pkg::*; (
   input  logic       axi4s_in,
   input  logic       rst_n,
   input  axis_word_t rx_word,
   input  logic       rx_valid,
   output logic       rx_ready,
   output axis_word_t tx_word,
   output logic       tx_valid,
   input  logic       tx_ready,
   input  wb_req_t    wb_req,
   output wb_rsp_t    wb_rsp
);

   // ==============================
   // stage interconnect.
   // ==============================
   hdr_cfg_t   cfg;
   logic       drop_hit;

   // drop filter to prefix inserter.
   axis_word_t dp_word;
   logic       dp_valid;
   logic       dp_ready;

   // prefix inserter to truncator.
   axis_word_t pt_word;
   logic       pt_valid;
   logic       pt_ready;

   // truncator to output fifo.
   axis_word_t tf_word;
   logic       tf_valid;
   logic       tf_ready;

   // register block, config fans out to every stage.
   hdr_cfg_regs u_regs (
      .axi4s_in (axi4s_in),
      .rst_n    (rst_n),
      .wb_req   (wb_req),
      .drop_hit (drop_hit),
      .wb_rsp   (wb_rsp),
      .cfg      (cfg)
   );

   hdr_drop_filter u_drop (
      .axi4s_in  (axi4s_in),
      .rst_n     (rst_n),
      .cfg       (cfg),
      .in_word   (rx_word),
      .in_valid  (rx_valid),
      .in_ready  (rx_ready),
      .out_word  (dp_word),
      .out_valid (dp_valid),
      .out_ready (dp_ready),
      .drop_hit  (drop_hit)
   );

   hdr_prefix_insert u_prefix (
      .axi4s_in  (axi4s_in),
      .rst_n     (rst_n),
      .cfg       (cfg),
      .in_word   (dp_word),
      .in_valid  (dp_valid),
      .in_ready  (dp_ready),
      .out_word  (pt_word),
      .out_valid (pt_valid),
      .out_ready (pt_ready)
   );

   hdr_truncate u_trunc (
      .axi4s_in  (axi4s_in),
      .rst_n     (rst_n),
      .cfg       (cfg),
      .in_word   (pt_word),
      .in_valid  (pt_valid),
      .in_ready  (pt_ready),
      .out_word  (tf_word),
      .out_valid (tf_valid),
      .out_ready (tf_ready)
   );

   // output buffer.
   hdr_pkt_fifo u_fifo (
      .axi4s_in  (axi4s_in),
      .rst_n     (rst_n),
      .in_word   (tf_word),
      .in_valid  (tf_valid),
      .in_ready  (tf_ready),
      .out_word  (tx_word),
      .out_valid (tx_valid),
      .out_ready (tx_ready)
   );

endmodule

`default_nettype wire

/* bench/hdr_proc_tb.sv */
`default_nettype none

`include "hdr_proc_params.svh"

module hdr_proc_tb import hdr_proc_pkg::*; ();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int NB = `HP_DATA_BYTES;
   localparam int TIMEOUT = 2000;
   localparam logic [31:0] SEED = 32'ha4f6_7f3a;

   typedef logic [7:0] byte_q_t[$];

   logic       axi4s_in;
   logic       rst_n;
   axis_word_t rx_word;
   logic       rx_valid;
   logic       rx_ready;
   axis_word_t tx_word;
   logic       tx_valid;
   logic       tx_ready;
   wb_req_t    wb_req;
   wb_rsp_t    wb_rsp;

   logic [31:0] lfsr;
   logic        bp_en;
   axis_word_t  exp_q[$];
   axis_word_t  mon_exp;

   // configuration as the testbench believes it was written.
   logic        m_drop_en;
   logic        m_drop_mode;
   word_t       m_drop_pat;
   int          m_prefix_len;
   int          m_trunc_len;
   word_t       m_prefix[`HP_PREFIX_WORDS];
   int          drops_expected;

   hdr_proc UUT (
      .axi4s_in (axi4s_in),
      .rst_n    (rst_n),
      .rx_word  (rx_word),
      .rx_valid (rx_valid),
      .rx_ready (rx_ready),
      .tx_word  (tx_word),
      .tx_valid (tx_valid),
      .tx_ready (tx_ready),
      .wb_req   (wb_req),
      .wb_rsp   (wb_rsp)
   );

   // 20 ns period.
   always #10 axi4s_in = ~axi4s_in;

   // ==============================
   // helpers.
   // ==============================
   // fibonacci lfsr, taps 32 22 2 1.
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // one step per bit taken.
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         r = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   task automatic fail_now(input string why);
      $display("%s", why);
      $display("** FAIL **");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
         $display("** FAIL **");
         $fatal(1);
      end
   endtask

   // top n lanes enabled, byte 0 in the top lane.
   function automatic keep_t keep_top(input int n);
      keep_t k;
      k = '0;
      for (int i = 0; i < n; i++) k[NB-1-i] = 1'b1;
      return k;
   endfunction

   function automatic int keep_count(input keep_t k);
      int n;
      n = 0;
      for (int i = 0; i < NB; i++) n += k[i];
      return n;
   endfunction

   function automatic word_t lane_mask(input keep_t k);
      word_t m;
      for (int i = 0; i < NB; i++) m[8*i +: 8] = {8{k[i]}};
      return m;
   endfunction

   // unused lanes are left at zero.
   function automatic axis_word_t pack_word(input byte_q_t b, input int pos);
      axis_word_t w;
      w = '0;
      for (int i = 0; i < NB; i++) begin
         if (pos + i < b.size()) begin
            w.tdata[8*(NB-1-i) +: 8] = b[pos+i];
            w.tkeep[NB-1-i] = 1'b1;
         end
      end
      w.tlast = (pos + NB >= b.size());
      return w;
   endfunction

   // ==============================
   // reference model.
   // ==============================
   // drop rule, then prefix, then truncation.
   function automatic void build_expected(input byte_q_t b);
      axis_word_t words[$];
      axis_word_t w;
      int cnt;
      int n;
      for (int pos = 0; pos < b.size(); pos += NB) words.push_back(pack_word(b, pos));
      if (m_drop_en && (words[0].tdata == m_drop_pat)) begin
         drops_expected++;
         if (m_drop_mode) return;
         // mode 0 leaves one empty closing word.
         w = words[0];
         w.tkeep = '0;
         w.tlast = 1'b1;
         words.delete();
         words.push_back(w);
      end
      for (int i = m_prefix_len - 1; i >= 0; i--) begin
         words.push_front('{tdata: m_prefix[i], tkeep: '1, tlast: 1'b0});
      end
      cnt = 0;
      for (int j = 0; j < words.size(); j++) begin
         w = words[j];
         n = keep_count(w.tkeep);
         if ((m_trunc_len != 0) && (n != 0) && (cnt + n >= m_trunc_len)) begin
            w.tkeep = keep_top(m_trunc_len - cnt);
            w.tlast = 1'b1;
            exp_q.push_back(w);
            break;
         end
         exp_q.push_back(w);
         cnt += n;
      end
   endfunction

   // ==============================
   // bus and stream drivers.
   // ==============================
   task automatic wb_access(input logic we, input wb_adr_t adr, input word_t wdat,
                            output word_t rdat);
      int n;
      logic got;
      n = 0;
      got = 1'b0;
      @(posedge axi4s_in);
      wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
      while (!got) begin
         @(negedge axi4s_in);
         if (wb_rsp.ack) begin
            got = 1'b1;
            rdat = wb_rsp.dat;
         end else begin
            n++;
            if (n > TIMEOUT) fail_now("timeout waiting for the wishbone ack");
         end
      end
      @(posedge axi4s_in);
      wb_req <= '0;
   endtask

   task automatic wb_write(input wb_adr_t adr, input word_t dat);
      word_t unused;
      wb_access(1'b1, adr, dat, unused);
   endtask

   task automatic check_reg(input wb_adr_t adr, input word_t exp);
      word_t got;
      wb_access(1'b0, adr, '0, got);
      check_value($sformatf("wb_rsp.dat[%0d]", adr), got, exp);
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (exp_q.size() != 0) begin
         @(negedge axi4s_in);
         n++;
         if (n > TIMEOUT) fail_now("timeout waiting for expected output words to come out");
      end
   endtask

   // only changes config with nothing in flight.
   task automatic set_cfg(input logic den, input logic dmode, input word_t pat,
                          input int plen, input int tlen);
      wait_drain();
      @(negedge axi4s_in);
      for (int i = 0; i < `HP_PREFIX_WORDS; i++) m_prefix[i] = rand_bits(32);
      m_drop_en    = den;
      m_drop_mode  = dmode;
      m_drop_pat   = pat;
      m_prefix_len = plen;
      m_trunc_len  = tlen;
      wb_write(`HP_REG_CTRL, word_t'({dmode, den}));
      wb_write(`HP_REG_DROP_PAT, pat);
      wb_write(`HP_REG_PREFIX_LEN, word_t'(plen));
      wb_write(`HP_REG_TRUNC_LEN, word_t'(tlen));
      for (int i = 0; i < `HP_PREFIX_WORDS; i++) begin
         wb_write(wb_adr_t'(`HP_REG_PREFIX0 + i), m_prefix[i]);
      end
   endtask

   // bytes drawn at the falling edge, clear of the tx_ready process.
   task automatic make_packet(input int len, output byte_q_t b);
      @(negedge axi4s_in);
      b.delete();
      for (int i = 0; i < len; i++) b.push_back(rand_bits(8));
   endtask

   task automatic send_packet(input byte_q_t b);
      int pos;
      int n;
      logic done;
      pos = 0;
      while (pos < b.size()) begin
         @(posedge axi4s_in);
         // queue the expectation before the first word goes in.
         if (pos == 0) build_expected(b);
         rx_word  <= pack_word(b, pos);
         rx_valid <= 1'b1;
         n = 0;
         done = 1'b0;
         while (!done) begin
            @(negedge axi4s_in);
            if (rx_ready) begin
               done = 1'b1;
            end else begin
               n++;
               if (n > TIMEOUT) fail_now("timeout waiting for rx_ready to take an input word");
            end
         end
         pos += NB;
      end
      @(posedge axi4s_in);
      rx_valid <= 1'b0;
   endtask

   // ==============================
   // test groups.
   // ==============================
   task automatic run_prefix();
      byte_q_t b;
      int len;
      for (int p = 1; p <= `HP_PREFIX_WORDS; p++) begin
         set_cfg(1'b0, 1'b0, '0, p, 0);
         for (int k = 0; k < 3; k++) begin
            // length drawn at the falling edge as well.
            @(negedge axi4s_in);
            len = 1 + int'(rand_bits(4));
            make_packet(len, b);
            send_packet(b);
         end
      end
   endtask

   task automatic run_trunc();
      byte_q_t b;
      int len;
      for (int t = 1; t <= 16; t++) begin
         for (int p = 0; p <= 2; p += 2) begin
            set_cfg(1'b0, 1'b0, '0, p, t);
            for (int k = 0; k < 2; k++) begin
               @(negedge axi4s_in);
               len = 1 + int'(rand_bits(5) % 20);
               make_packet(len, b);
               send_packet(b);
            end
         end
      end
   endtask

   // every other packet starts with the pattern.
   task automatic run_drop(input logic mode);
      byte_q_t b;
      word_t pat;
      int len;
      @(negedge axi4s_in);
      pat = rand_bits(32);
      set_cfg(1'b1, mode, pat, 0, 0);
      for (int k = 0; k < 6; k++) begin
         @(negedge axi4s_in);
         len = NB + int'(rand_bits(4) % 12);
         make_packet(len, b);
         if (k % 2 == 0) begin
            for (int i = 0; i < NB; i++) b[i] = pat[8*(NB-1-i) +: 8];
         end
         send_packet(b);
      end
      wait_drain();
      check_reg(`HP_REG_DROP_CNT, word_t'(drops_expected));
      // clear the counter for the next group.
      wb_write(`HP_REG_DROP_CNT, '0);
      drops_expected = 0;
      check_reg(`HP_REG_DROP_CNT, '0);
   endtask

   // ==============================
   // output side.
   // ==============================
   always @(posedge axi4s_in) begin
      if (bp_en) tx_ready <= (rand_bits(1) != 0);
      else       tx_ready <= 1'b1;
   end

   // transfer happens on the next rising edge.
   always @(negedge axi4s_in) begin
      if (rst_n && tx_valid && tx_ready) begin
         if (exp_q.size() == 0) begin
            fail_now("an output word came out when none was expected");
         end else begin
            mon_exp = exp_q.pop_front();
            check_value("tx_word.tkeep", tx_word.tkeep, mon_exp.tkeep);
            check_value("tx_word.tlast", tx_word.tlast, mon_exp.tlast);
            check_value("tx_word.tdata", tx_word.tdata & lane_mask(mon_exp.tkeep),
                        mon_exp.tdata & lane_mask(mon_exp.tkeep));
         end
      end
   end

   // ==============================
   // sequence.
   // ==============================
   initial begin
      byte_q_t b;
      axi4s_in       = 1'b0;
      rst_n          = 1'b0;
      rx_word        = '0;
      rx_valid       = 1'b0;
      tx_ready       = 1'b1;
      wb_req         = '0;
      bp_en          = 1'b0;
      lfsr           = SEED;
      m_drop_en      = 1'b0;
      m_drop_mode    = 1'b0;
      m_drop_pat     = '0;
      m_prefix_len   = 0;
      m_trunc_len    = 0;
      drops_expected = 0;
      repeat (3) @(posedge axi4s_in);
      rst_n <= 1'b1;
      @(negedge axi4s_in);
      check_value("tx_valid", tx_valid, 1'b0);
      check_value("rx_ready", rx_ready, 1'b1);
      check_value("wb_rsp.ack", wb_rsp.ack, 1'b0);

      // every register is zero out of reset.
      for (int a = 0; a <= `HP_REG_DROP_CNT; a++) check_reg(wb_adr_t'(a), '0);

      // write and read back.
      wb_write(`HP_REG_CTRL, 32'h3);
      wb_write(`HP_REG_DROP_PAT, 32'h5aa5_c33c);
      wb_write(`HP_REG_PREFIX_LEN, 32'h3);
      wb_write(`HP_REG_TRUNC_LEN, 32'hb7);
      for (int i = 0; i < `HP_PREFIX_WORDS; i++) begin
         wb_write(wb_adr_t'(`HP_REG_PREFIX0 + i), 32'h1357_9bdf ^ (i << 8));
      end
      check_reg(`HP_REG_CTRL, 32'h3);
      check_reg(`HP_REG_DROP_PAT, 32'h5aa5_c33c);
      check_reg(`HP_REG_PREFIX_LEN, 32'h3);
      check_reg(`HP_REG_TRUNC_LEN, 32'hb7);
      for (int i = 0; i < `HP_PREFIX_WORDS; i++) begin
         check_reg(wb_adr_t'(`HP_REG_PREFIX0 + i), 32'h1357_9bdf ^ (i << 8));
      end

      // plain passthrough, every length from 1 to 20 bytes.
      set_cfg(1'b0, 1'b0, '0, 0, 0);
      for (int len = 1; len <= 20; len++) begin
         make_packet(len, b);
         send_packet(b);
      end

      // second pass runs with random tx_ready.
      for (int pass = 0; pass < 2; pass++) begin
         wait_drain();
         @(negedge axi4s_in);
         bp_en = (pass == 1);
         run_prefix();
         run_trunc();
         run_drop(1'b0);
         run_drop(1'b1);
      end

      wait_drain();
      $display("** PASS **");
      $finish;
   end

endmodule

`default_nettype wire

/* hdr_proc.f */
+incdir+rtl
rtl/hdr_proc_pkg.sv
rtl/hdr_cfg_regs.sv
rtl/hdr_drop_filter.sv
rtl/hdr_prefix_insert.sv
rtl/hdr_truncate.sv
rtl/hdr_pkt_fifo.sv
rtl/hdr_proc.sv
bench/hdr_proc_tb.sv

/* Bender.yml */
package:
  name: hdr_proc

export_include_dirs:
  - rtl

sources:
  - rtl/hdr_proc_pkg.sv
  - rtl/hdr_cfg_regs.sv
  - rtl/hdr_drop_filter.sv
  - rtl/hdr_prefix_insert.sv
  - rtl/hdr_truncate.sv
  - rtl/hdr_pkt_fifo.sv
  - rtl/hdr_proc.sv
  - target: test
    files:
      - bench/hdr_proc_tb.sv
